// File: rooth_pkg.sv
// widths, slave codes and timer register map shared by the soc blocks
// slave index is address bits 31:28, slaves only see the low 28 bits
`default_nettype none

package rooth_pkg;

    localparam int CPU_WIDTH      = 32;
    localparam int SEL_WIDTH      = 4;
    localparam int SLV_ADDR_WIDTH = CPU_WIDTH - SEL_WIDTH;   // offset inside a slave

    typedef logic [CPU_WIDTH-1:0] cpu_word_t;    // address and data
    typedef logic [SEL_WIDTH-1:0] slave_sel_t;   // top address nibble

    // ------------------------------------------------------------------------
    // slave select codes
    // ------------------------------------------------------------------------
    localparam slave_sel_t SLV_MEM0  = 4'h0;   // instruction / data rom
    localparam slave_sel_t SLV_MEM1  = 4'h1;   // data ram
    localparam slave_sel_t SLV_TIMER = 4'h2;   // machine timer
    // 3..15 unmapped

    // ------------------------------------------------------------------------
    // timer registers
    // ------------------------------------------------------------------------
    // byte offsets, only bits 3:2 are decoded
    localparam logic [3:0] TMR_CTRL_OFS  = 4'h0;
    localparam logic [3:0] TMR_COUNT_OFS = 4'h4;
    localparam logic [3:0] TMR_CMP_OFS   = 4'h8;

    // control register fields
    localparam int TMR_CTRL_EN_BIT   = 0;   // count enable
    localparam int TMR_CTRL_IE_BIT   = 1;   // interrupt enable
    localparam int TMR_CTRL_PEND_BIT = 2;   // sticky, write 0 to clear

endpackage

`default_nettype wire

// File: rooth_bus.sv
// fixed priority bus, m3 > m2 > m0 > m1, no stall and no retry
// a losing master reads zero and its write is lost
// master 1 is read-only and always sees slave 0 read data
`timescale 1ns/1ns
`default_nettype none

module rooth_bus
    import rooth_pkg::*;
(
    input  wire            clk,
    input  wire            rst_n_i,

    // master 0, core data
    input  wire cpu_word_t m0_addr_i,
    input  wire cpu_word_t m0_data_i,
    input  wire            m0_req_i,
    input  wire            m0_we_i,
    output cpu_word_t      m0_data_o,

    // master 1, instruction fetch
    input  wire cpu_word_t m1_addr_i,
    output cpu_word_t      m1_data_o,

    // master 2, debug
    input  wire cpu_word_t m2_addr_i,
    input  wire cpu_word_t m2_data_i,
    input  wire            m2_req_i,
    input  wire            m2_we_i,
    output cpu_word_t      m2_data_o,

    // master 3, other
    input  wire cpu_word_t m3_addr_i,
    input  wire cpu_word_t m3_data_i,
    input  wire            m3_req_i,
    input  wire            m3_we_i,
    output cpu_word_t      m3_data_o,

    // slaves
    output cpu_word_t      s0_addr_o,
    output cpu_word_t      s0_data_o,
    output logic           s0_we_o,
    input  wire cpu_word_t s0_data_i,

    output cpu_word_t      s1_addr_o,
    output cpu_word_t      s1_data_o,
    output logic           s1_we_o,
    input  wire cpu_word_t s1_data_i,

    output cpu_word_t      s2_addr_o,
    output cpu_word_t      s2_data_o,
    output logic           s2_we_o,
    input  wire cpu_word_t s2_data_i
);

    localparam logic [1:0] GNT_M0 = 2'd0;
    localparam logic [1:0] GNT_M1 = 2'd1;
    localparam logic [1:0] GNT_M2 = 2'd2;
    localparam logic [1:0] GNT_M3 = 2'd3;

    logic [1:0] grant;
    logic       g_req;      // a writing-capable master owns the bus
    cpu_word_t  g_addr;
    cpu_word_t  g_data;
    logic       g_we;
    slave_sel_t g_sel;
    cpu_word_t  g_addr_s;   // slave view, top nibble cleared
    cpu_word_t  rd_data;

    // ------------------------------------------------------------------------
    // arbitration
    // ------------------------------------------------------------------------
    always_comb begin
        if (m3_req_i) begin
            grant = GNT_M3;
        end else if (m2_req_i) begin
            grant = GNT_M2;
        end else if (m0_req_i) begin
            grant = GNT_M0;
        end else begin
            grant = GNT_M1;   // fetch owns an idle bus
        end
    end

    // granted master's request, muxed once so the decode is shared
    always_comb begin
        case (grant)
            GNT_M3: begin
                g_addr = m3_addr_i;
                g_data = m3_data_i;
                g_we   = m3_we_i;
            end
            GNT_M2: begin
                g_addr = m2_addr_i;
                g_data = m2_data_i;
                g_we   = m2_we_i;
            end
            GNT_M0: begin
                g_addr = m0_addr_i;
                g_data = m0_data_i;
                g_we   = m0_we_i;
            end
            default: begin
                g_addr = m1_addr_i;
                g_data = '0;
                g_we   = 1'b0;    // no write path for fetch
            end
        endcase
    end

    assign g_req    = (grant != GNT_M1);
    assign g_sel    = g_addr[CPU_WIDTH-1 -: SEL_WIDTH];
    assign g_addr_s = {{SEL_WIDTH{1'b0}}, g_addr[SLV_ADDR_WIDTH-1:0]};

    // ------------------------------------------------------------------------
    // address decode and slave routing
    // ------------------------------------------------------------------------
    always_comb begin
        // slave 0 address follows fetch unless taken below
        s0_addr_o = {{SEL_WIDTH{1'b0}}, m1_addr_i[SLV_ADDR_WIDTH-1:0]};
        s0_data_o = '0;
        s0_we_o   = 1'b0;
        s1_addr_o = '0;
        s1_data_o = '0;
        s1_we_o   = 1'b0;
        s2_addr_o = '0;
        s2_data_o = '0;
        s2_we_o   = 1'b0;
        rd_data   = '0;
        if (g_req) begin
            case (g_sel)
                SLV_MEM0: begin
                    s0_addr_o = g_addr_s;
                    s0_data_o = g_data;
                    s0_we_o   = g_we;
                    rd_data   = s0_data_i;
                end
                SLV_MEM1: begin
                    s1_addr_o = g_addr_s;
                    s1_data_o = g_data;
                    s1_we_o   = g_we;
                    rd_data   = s1_data_i;
                end
                SLV_TIMER: begin
                    s2_addr_o = g_addr_s;
                    s2_data_o = g_data;
                    s2_we_o   = g_we;
                    rd_data   = s2_data_i;
                end
                default: rd_data = '0;   // unmapped, write dropped
            endcase
        end
    end

    // read data only to the winner
    assign m0_data_o = (grant == GNT_M0) ? rd_data : '0;
    assign m2_data_o = (grant == GNT_M2) ? rd_data : '0;
    assign m3_data_o = (grant == GNT_M3) ? rd_data : '0;
    assign m1_data_o = s0_data_i;

endmodule

`default_nettype wire

// File: rooth_mem.sv
// word memory, write at the clock edge, read is combinational
// WORDS must be a power of two >= 2, higher address bits alias
`timescale 1ns/1ns
`default_nettype none

module rooth_mem
    import rooth_pkg::*;
#(
    parameter int WORDS = 256
) (
    input  wire            clk,
    input  wire            rst_n_i,

    input  wire cpu_word_t addr_i,
    input  wire cpu_word_t data_i,
    input  wire            we_i,
    output cpu_word_t      data_o
);

    localparam int IDX_W = $clog2(WORDS);

    cpu_word_t        mem [WORDS];
    logic [IDX_W-1:0] idx;

    // byte address to word index
    assign idx = addr_i[2 +: IDX_W];

    // contents cleared on reset
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (we_i) begin
            mem[idx] <= data_i;
        end
    end

    assign data_o = mem[idx];   // same cycle read

endmodule

`default_nettype wire

// File: rooth_timer.sv
// machine timer, counts while enabled and wraps to zero on compare match
// pending is sticky until a control write with bit 2 clear
`timescale 1ns/1ns
`default_nettype none

module rooth_timer
    import rooth_pkg::*;
(
    input  wire            clk,
    input  wire            rst_n_i,

    input  wire cpu_word_t addr_i,
    input  wire cpu_word_t data_i,
    input  wire            we_i,
    output cpu_word_t      data_o,

    output logic           irq_o
);

    logic       ctrl_en;
    logic       ctrl_ie;
    logic       ctrl_pend;
    cpu_word_t  count_q;
    cpu_word_t  cmp_q;

    logic       en_d;
    logic       ie_d;
    logic       pend_d;
    cpu_word_t  count_d;

    logic [3:0] ofs;
    logic       wr_ctrl;
    logic       wr_count;
    logic       wr_cmp;
    logic       match;

    // ------------------------------------------------------------------------
    // register select
    // ------------------------------------------------------------------------
    assign ofs      = {addr_i[3:2], 2'b00};
    assign wr_ctrl  = we_i && (ofs == TMR_CTRL_OFS);
    assign wr_count = we_i && (ofs == TMR_COUNT_OFS);
    assign wr_cmp   = we_i && (ofs == TMR_CMP_OFS);

    assign match = ctrl_en && (count_q == cmp_q);

    // ------------------------------------------------------------------------
    // next state
    // ------------------------------------------------------------------------
    always_comb begin
        en_d    = ctrl_en;
        ie_d    = ctrl_ie;
        pend_d  = ctrl_pend;
        count_d = count_q;
        if (ctrl_en) begin
            count_d = count_q + 1'b1;
        end
        if (match) begin
            count_d = '0;              // wrap
        end
        if (wr_count) begin
            count_d = data_i;          // bus write wins
        end
        if (wr_ctrl) begin
            en_d = data_i[TMR_CTRL_EN_BIT];
            ie_d = data_i[TMR_CTRL_IE_BIT];
            if (!data_i[TMR_CTRL_PEND_BIT]) begin
                pend_d = 1'b0;
            end
        end
        // a match in the same cycle keeps pending set
        if (match) begin
            pend_d = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ctrl_en   <= 1'b0;
            ctrl_ie   <= 1'b0;
            ctrl_pend <= 1'b0;
            count_q   <= '0;
            cmp_q     <= '0;
            irq_o     <= 1'b0;
        end else begin
            ctrl_en   <= en_d;
            ctrl_ie   <= ie_d;
            ctrl_pend <= pend_d;
            count_q   <= count_d;
            if (wr_cmp) begin
                cmp_q <= data_i;
            end
            irq_o     <= pend_d & ie_d;   // tracks pend & ie on the same edge
        end
    end

    // readback, offset 0xc reads zero
    always_comb begin
        data_o = '0;
        case (ofs)
            TMR_CTRL_OFS: begin
                data_o[TMR_CTRL_EN_BIT]   = ctrl_en;
                data_o[TMR_CTRL_IE_BIT]   = ctrl_ie;
                data_o[TMR_CTRL_PEND_BIT] = ctrl_pend;
            end
            TMR_COUNT_OFS: data_o = count_q;
            TMR_CMP_OFS:   data_o = cmp_q;
            default:       data_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: rooth_soc.sv
// soc bus top, rom at 0x0xxxxxxx, ram at 0x1xxxxxxx, timer at 0x2xxxxxxx
// the four masters are driven from outside
`timescale 1ns/1ns
`default_nettype none

module rooth_soc
    import rooth_pkg::*;
#(
    parameter int MEM0_WORDS = 256,
    parameter int MEM1_WORDS = 128
) (
    input  wire            clk,
    input  wire            rst_n_i,

    input  wire cpu_word_t m0_addr_i,
    input  wire cpu_word_t m0_data_i,
    input  wire            m0_req_i,
    input  wire            m0_we_i,
    output cpu_word_t      m0_data_o,

    input  wire cpu_word_t m1_addr_i,
    output cpu_word_t      m1_data_o,

    input  wire cpu_word_t m2_addr_i,
    input  wire cpu_word_t m2_data_i,
    input  wire            m2_req_i,
    input  wire            m2_we_i,
    output cpu_word_t      m2_data_o,

    input  wire cpu_word_t m3_addr_i,
    input  wire cpu_word_t m3_data_i,
    input  wire            m3_req_i,
    input  wire            m3_we_i,
    output cpu_word_t      m3_data_o,

    output logic           timer_irq_o
);

    // slave side of the bus
    cpu_word_t s0_addr;
    cpu_word_t s0_wdata;
    cpu_word_t s0_rdata;
    logic      s0_we;
    cpu_word_t s1_addr;
    cpu_word_t s1_wdata;
    cpu_word_t s1_rdata;
    logic      s1_we;
    cpu_word_t s2_addr;
    cpu_word_t s2_wdata;
    cpu_word_t s2_rdata;
    logic      s2_we;

    rooth_bus u_bus (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .m0_addr_i (m0_addr_i),
        .m0_data_i (m0_data_i),
        .m0_req_i  (m0_req_i),
        .m0_we_i   (m0_we_i),
        .m0_data_o (m0_data_o),
        .m1_addr_i (m1_addr_i),
        .m1_data_o (m1_data_o),
        .m2_addr_i (m2_addr_i),
        .m2_data_i (m2_data_i),
        .m2_req_i  (m2_req_i),
        .m2_we_i   (m2_we_i),
        .m2_data_o (m2_data_o),
        .m3_addr_i (m3_addr_i),
        .m3_data_i (m3_data_i),
        .m3_req_i  (m3_req_i),
        .m3_we_i   (m3_we_i),
        .m3_data_o (m3_data_o),
        .s0_addr_o (s0_addr),
        .s0_data_o (s0_wdata),
        .s0_we_o   (s0_we),
        .s0_data_i (s0_rdata),
        .s1_addr_o (s1_addr),
        .s1_data_o (s1_wdata),
        .s1_we_o   (s1_we),
        .s1_data_i (s1_rdata),
        .s2_addr_o (s2_addr),
        .s2_data_o (s2_wdata),
        .s2_we_o   (s2_we),
        .s2_data_i (s2_rdata)
    );

    // slave 0, rom style memory (writable from the bus)
    rooth_mem #(.WORDS(MEM0_WORDS)) u_mem0 (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .addr_i  (s0_addr),
        .data_i  (s0_wdata),
        .we_i    (s0_we),
        .data_o  (s0_rdata)
    );

    rooth_mem #(.WORDS(MEM1_WORDS)) u_mem1 (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .addr_i  (s1_addr),
        .data_i  (s1_wdata),
        .we_i    (s1_we),
        .data_o  (s1_rdata)
    );

    rooth_timer u_timer (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .addr_i  (s2_addr),
        .data_i  (s2_wdata),
        .we_i    (s2_we),
        .data_o  (s2_rdata),
        .irq_o   (timer_irq_o)
    );

endmodule

`default_nettype wire

// File: rooth_soc_assert.sv
// bus rules checked at every rising edge outside reset
`timescale 1ns/1ns
`default_nettype none

module rooth_soc_assert
    import rooth_pkg::*;
(
    input  wire            clk,
    input  wire            rst_n_i,
    input  wire            m0_req_i,
    input  wire            m2_req_i,
    input  wire            m3_req_i,
    input  wire cpu_word_t s0_addr_o,
    input  wire cpu_word_t s1_addr_o,
    input  wire cpu_word_t s2_addr_o,
    input  wire            s0_we_o,
    input  wire            s1_we_o,
    input  wire            s2_we_o
);

    int fail_count = 0;   // read by the testbench top

    we_onehot: assert property (@(posedge clk) disable iff (!rst_n_i)
        $onehot0({s0_we_o, s1_we_o, s2_we_o}))
        else begin
            fail_count++;
            $error("more than one slave write enable is high");
        end

    we_needs_req: assert property (@(posedge clk) disable iff (!rst_n_i)
        (s0_we_o || s1_we_o || s2_we_o) |-> (m0_req_i || m2_req_i || m3_req_i))
        else begin
            fail_count++;
            $error("slave write enable without any master request");
        end

    // slaves only ever see the low 28 bits
    addr_nibble: assert property (@(posedge clk) disable iff (!rst_n_i)
        (s0_addr_o[31:28] == '0) && (s1_addr_o[31:28] == '0) && (s2_addr_o[31:28] == '0))
        else begin
            fail_count++;
            $error("slave address has a nonzero top nibble");
        end

endmodule

bind rooth_bus rooth_soc_assert u_assert (.*);

`default_nettype wire

// File: rooth_soc_checker.sv
// model of arbitration, both memories and the timer, compared on the falling edge
// the model steps on the rising edge with the request seen on the falling edge before
`timescale 1ns/1ns
`default_nettype none

module rooth_soc_checker
    import rooth_pkg::*;
#(
    parameter int MEM0_WORDS = 256,
    parameter int MEM1_WORDS = 128
) (
    input  wire            clk,
    input  wire            rst_n_i,
    input  wire cpu_word_t m0_addr_i,
    input  wire cpu_word_t m0_data_i,
    input  wire            m0_req_i,
    input  wire            m0_we_i,
    input  wire cpu_word_t m1_addr_i,
    input  wire cpu_word_t m2_addr_i,
    input  wire cpu_word_t m2_data_i,
    input  wire            m2_req_i,
    input  wire            m2_we_i,
    input  wire cpu_word_t m3_addr_i,
    input  wire cpu_word_t m3_data_i,
    input  wire            m3_req_i,
    input  wire            m3_we_i,
    input  wire cpu_word_t m0_rdata_i,
    input  wire cpu_word_t m1_rdata_i,
    input  wire cpu_word_t m2_rdata_i,
    input  wire cpu_word_t m3_rdata_i,
    input  wire            irq_i,
    input  wire [2:0]      test_id_i,
    input  wire            test_end_i,
    output int             tests_run_o,
    output int             tests_failed_o,
    output int             errors_o
);

    localparam int IDX0_W = $clog2(MEM0_WORDS);
    localparam int IDX1_W = $clog2(MEM1_WORDS);

    cpu_word_t  mem0 [MEM0_WORDS];
    cpu_word_t  mem1 [MEM1_WORDS];
    logic       t_en;
    logic       t_ie;
    logic       t_pend;
    logic       t_irq;
    cpu_word_t  t_count;
    cpu_word_t  t_cmp;
    logic       match;
    logic [1:0] win;                  // granted master number
    cpu_word_t  w_addr;
    cpu_word_t  w_data;
    logic       w_we;
    cpu_word_t  s0_addr;
    logic       wr_en;                // write captured for the next edge
    cpu_word_t  wr_addr;
    cpu_word_t  wr_data;
    int         test_errors = 0;
    int         n_run = 0;
    int         n_failed = 0;
    int         n_errors = 0;

    assign tests_run_o    = n_run;
    assign tests_failed_o = n_failed;
    assign errors_o       = n_errors;

    function automatic string test_name(input logic [2:0] id);
        case (id)
            3'd0:    return "mem_rw";
            3'd1:    return "priority";
            3'd2:    return "fetch";
            3'd3:    return "unmapped";
            3'd4:    return "timer";
            default: return "alias";
        endcase
    endfunction

    // what a granted read of this address should return
    function automatic cpu_word_t slave_read(input cpu_word_t addr);
        cpu_word_t ctrl;
        ctrl = '0;
        ctrl[TMR_CTRL_EN_BIT]   = t_en;
        ctrl[TMR_CTRL_IE_BIT]   = t_ie;
        ctrl[TMR_CTRL_PEND_BIT] = t_pend;
        case (addr[31:28])
            SLV_MEM0: return mem0[addr[2 +: IDX0_W]];
            SLV_MEM1: return mem1[addr[2 +: IDX1_W]];
            SLV_TIMER: begin
                if ({addr[3:2], 2'b00} == TMR_CTRL_OFS)  return ctrl;
                if ({addr[3:2], 2'b00} == TMR_COUNT_OFS) return t_count;
                if ({addr[3:2], 2'b00} == TMR_CMP_OFS)   return t_cmp;
                return '0;
            end
            default: return '0;
        endcase
    endfunction

    task automatic compare(input string port, input cpu_word_t exp, input cpu_word_t act);
        if (act !== exp) begin
            $display("ERROR %s expected 0x%08h actual 0x%08h on %s",
                     test_name(test_id_i), exp, act, port);
            test_errors++;
            n_errors++;
        end
    endtask

    // ------------------------------------------------------------------------
    // compare on the falling edge
    // ------------------------------------------------------------------------
    always @(negedge clk) begin
        win    = 2'd1;
        w_addr = m1_addr_i;
        w_data = '0;
        w_we   = 1'b0;
        if (m3_req_i) begin
            win = 2'd3;
            w_addr = m3_addr_i;
            w_data = m3_data_i;
            w_we = m3_we_i;
        end else if (m2_req_i) begin
            win = 2'd2;
            w_addr = m2_addr_i;
            w_data = m2_data_i;
            w_we = m2_we_i;
        end else if (m0_req_i) begin
            win = 2'd0;
            w_addr = m0_addr_i;
            w_data = m0_data_i;
            w_we = m0_we_i;
        end
        // fetch shares slave 0 and loses its address to a granted master
        s0_addr = (win != 2'd1 && w_addr[31:28] == SLV_MEM0) ? w_addr : m1_addr_i;
        wr_en   = rst_n_i && w_we;
        wr_addr = w_addr;
        wr_data = w_data;
        if (rst_n_i) begin
            compare("m0_data_o", (win == 2'd0) ? slave_read(w_addr) : '0, m0_rdata_i);
            compare("m2_data_o", (win == 2'd2) ? slave_read(w_addr) : '0, m2_rdata_i);
            compare("m3_data_o", (win == 2'd3) ? slave_read(w_addr) : '0, m3_rdata_i);
            compare("m1_data_o", mem0[s0_addr[2 +: IDX0_W]], m1_rdata_i);
            compare("timer_irq_o", {31'd0, t_irq}, {31'd0, irq_i});
        end
        if (test_end_i) begin
            n_run++;
            if (test_errors == 0) begin
                $display("test %s ok", test_name(test_id_i));
            end else begin
                $display("test %s failed with %0d mismatches", test_name(test_id_i), test_errors);
                n_failed++;
            end
            test_errors = 0;
        end
    end

    // ------------------------------------------------------------------------
    // model state, stepped on the rising edge
    // ------------------------------------------------------------------------
    always @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < MEM0_WORDS; i++) mem0[i] = '0;
            for (int i = 0; i < MEM1_WORDS; i++) mem1[i] = '0;
            t_en    = 1'b0;
            t_ie    = 1'b0;
            t_pend  = 1'b0;
            t_irq   = 1'b0;
            t_count = '0;
            t_cmp   = '0;
        end else begin
            match = t_en && (t_count == t_cmp);
            if (wr_en && wr_addr[31:28] == SLV_MEM0) mem0[wr_addr[2 +: IDX0_W]] = wr_data;
            if (wr_en && wr_addr[31:28] == SLV_MEM1) mem1[wr_addr[2 +: IDX1_W]] = wr_data;
            if (wr_en && wr_addr[31:28] == SLV_TIMER &&
                {wr_addr[3:2], 2'b00} == TMR_COUNT_OFS) begin
                t_count = wr_data;            // write beats wrap and increment
            end else if (match) begin
                t_count = '0;
            end else if (t_en) begin
                t_count = t_count + 32'd1;
            end
            if (wr_en && wr_addr[31:28] == SLV_TIMER &&
                {wr_addr[3:2], 2'b00} == TMR_CTRL_OFS) begin
                t_en = wr_data[TMR_CTRL_EN_BIT];
                t_ie = wr_data[TMR_CTRL_IE_BIT];
                if (!wr_data[TMR_CTRL_PEND_BIT]) t_pend = 1'b0;
            end
            if (match) t_pend = 1'b1;
            if (wr_en && wr_addr[31:28] == SLV_TIMER &&
                {wr_addr[3:2], 2'b00} == TMR_CMP_OFS) begin
                t_cmp = wr_data;
            end
            t_irq = t_pend & t_ie;
        end
    end

endmodule

`default_nettype wire

// File: tb_rooth_soc.sv
// random four-master traffic against the soc from xorshift32 with seed 20
// the checker judges all results and this module only drives and reports
`timescale 1ns/1ns
`default_nettype none

module tb_rooth_soc
    import rooth_pkg::*;
();

    localparam int MEM0_WORDS = 256;
    localparam int MEM1_WORDS = 128;
    localparam int N_TESTS    = 6;
    localparam int T_PRIO     = 1;
    localparam int T_FETCH    = 2;
    localparam int T_UNMAPPED = 3;
    localparam int T_TIMER    = 4;
    localparam int T_ALIAS    = 5;
    localparam int TEST_CYCLES [N_TESTS] = '{200, 200, 120, 120, 150, 150};

    logic       clk;
    logic       rst_n;
    cpu_word_t  m0_addr;
    cpu_word_t  m0_wdata;
    cpu_word_t  m0_rdata;
    logic       m0_req;
    logic       m0_we;
    cpu_word_t  m1_addr;
    cpu_word_t  m1_rdata;
    cpu_word_t  m2_addr;
    cpu_word_t  m2_wdata;
    cpu_word_t  m2_rdata;
    logic       m2_req;
    logic       m2_we;
    cpu_word_t  m3_addr;
    cpu_word_t  m3_wdata;
    cpu_word_t  m3_rdata;
    logic       m3_req;
    logic       m3_we;
    logic       timer_irq;
    logic [2:0] test_id;
    logic       test_end;
    int         tests_run;
    int         tests_failed;
    int         mismatches;
    cpu_word_t  rng_state = 32'd20;

    rooth_soc #(.MEM0_WORDS(MEM0_WORDS), .MEM1_WORDS(MEM1_WORDS)) rooth_soc_i (
        .clk(clk), .rst_n_i(rst_n),
        .m0_addr_i(m0_addr), .m0_data_i(m0_wdata), .m0_req_i(m0_req), .m0_we_i(m0_we),
        .m0_data_o(m0_rdata),
        .m1_addr_i(m1_addr), .m1_data_o(m1_rdata),
        .m2_addr_i(m2_addr), .m2_data_i(m2_wdata), .m2_req_i(m2_req), .m2_we_i(m2_we),
        .m2_data_o(m2_rdata),
        .m3_addr_i(m3_addr), .m3_data_i(m3_wdata), .m3_req_i(m3_req), .m3_we_i(m3_we),
        .m3_data_o(m3_rdata),
        .timer_irq_o(timer_irq)
    );

    rooth_soc_checker #(.MEM0_WORDS(MEM0_WORDS), .MEM1_WORDS(MEM1_WORDS)) checker_i (
        .clk(clk), .rst_n_i(rst_n),
        .m0_addr_i(m0_addr), .m0_data_i(m0_wdata), .m0_req_i(m0_req), .m0_we_i(m0_we),
        .m1_addr_i(m1_addr),
        .m2_addr_i(m2_addr), .m2_data_i(m2_wdata), .m2_req_i(m2_req), .m2_we_i(m2_we),
        .m3_addr_i(m3_addr), .m3_data_i(m3_wdata), .m3_req_i(m3_req), .m3_we_i(m3_we),
        .m0_rdata_i(m0_rdata), .m1_rdata_i(m1_rdata), .m2_rdata_i(m2_rdata),
        .m3_rdata_i(m3_rdata), .irq_i(timer_irq),
        .test_id_i(test_id), .test_end_i(test_end),
        .tests_run_o(tests_run), .tests_failed_o(tests_failed), .errors_o(mismatches)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic cpu_word_t xorshift32(input cpu_word_t x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic cpu_word_t rand32();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    task automatic idle_masters();
        m0_req = 1'b0;
        m0_we  = 1'b0;
        m2_req = 1'b0;
        m2_we  = 1'b0;
        m3_req = 1'b0;
        m3_we  = 1'b0;
    endtask

    // one master's request for the cycle as the test shapes it
    task automatic gen_req(input int mode, input logic is_m0, output logic req,
                           output logic we, output cpu_word_t addr, output cpu_word_t data);
        cpu_word_t  r;
        cpu_word_t  hi;
        slave_sel_t nib;
        r    = rand32();
        hi   = rand32();
        data = rand32();
        we   = r[31];
        req  = is_m0;
        nib  = slave_sel_t'(r[0]);            // memory 0 or 1
        addr = '0;
        addr[2 +: 4] = r[11:8];               // 16 words so reads hit earlier writes
        if (mode == T_PRIO || mode == T_FETCH) begin
            req = (mode == T_PRIO) ? r[30] : (r[30:28] == 3'd0);
            if (r[7:4] < 4'd13) begin
                nib = slave_sel_t'(r[7:4] % 3);
            end else begin
                nib = slave_sel_t'(4'd3 + r[15:12] % 13);   // a few unmapped
            end
        end else if (mode == T_UNMAPPED) begin
            if (r[29]) begin
                nib = slave_sel_t'(4'd3 + r[15:12] % 13);
            end else begin
                nib = slave_sel_t'(r[7:4] % 3);   // memories and timer
                we  = 1'b0;                       // mapped read to spot stray writes
            end
        end else if (mode == T_ALIAS) begin
            addr[27:10] = hi[17:0];           // above both memory depths
        end
        addr[31:28] = nib;
    endtask

    // directed timer sequence with reads of random registers in between
    task automatic timer_step(input int c);
        cpu_word_t r;
        r        = rand32();
        m0_req   = 1'b1;
        m0_we    = 1'b1;
        m0_addr  = {SLV_TIMER, 24'h0, TMR_CTRL_OFS};
        m0_wdata = r;
        case (c)
            0: begin
                m0_addr  = {SLV_TIMER, 24'h0, TMR_CMP_OFS};
                m0_wdata = 32'd12;
            end
            1: begin
                m0_addr  = {SLV_TIMER, 24'h0, TMR_COUNT_OFS};
                m0_wdata = 32'd3;
            end
            2, 70: m0_wdata = 32'h3;          // en and ie set and pending cleared
            110:   m0_wdata = 32'h7;          // pending left as is
            default: begin
                m0_we   = 1'b0;
                m0_addr = {SLV_TIMER, 24'h0, r[3:2], 2'b00};
            end
        endcase
    endtask

    task automatic run_test(input int t);
        for (int c = 0; c < TEST_CYCLES[t]; c++) begin
            @(posedge clk);
            #2;
            test_id = 3'(t);
            if (t == T_TIMER) begin
                idle_masters();
                timer_step(c);
            end else begin
                gen_req(t, 1'b1, m0_req, m0_we, m0_addr, m0_wdata);
                gen_req(t, 1'b0, m2_req, m2_we, m2_addr, m2_wdata);
                gen_req(t, 1'b0, m3_req, m3_we, m3_addr, m3_wdata);
            end
            m1_addr = rand32();
        end
        @(posedge clk);
        #2;
        idle_masters();
        test_end = 1'b1;                      // checker reports on this cycle
        @(posedge clk);
        #2;
        test_end = 1'b0;
    endtask

    // ------------------------------------------------------------------------
    // main sequence and watchdog
    // ------------------------------------------------------------------------
    initial begin
        rst_n    = 1'b0;
        m0_addr  = '0;
        m0_wdata = '0;
        m1_addr  = '0;
        m2_addr  = '0;
        m2_wdata = '0;
        m3_addr  = '0;
        m3_wdata = '0;
        test_id  = '0;
        test_end = 1'b0;
        idle_masters();
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;
        for (int t = 0; t < N_TESTS; t++) begin
            run_test(t);
        end
        @(posedge clk);
        #2;
        $display("tests %0d, failed %0d, mismatches %0d, assertion failures %0d",
                 tests_run, tests_failed, mismatches, rooth_soc_i.u_bus.u_assert.fail_count);
        if (tests_run == N_TESTS && tests_failed == 0 && mismatches == 0 &&
            rooth_soc_i.u_bus.u_assert.fail_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    initial begin
        int budget;
        budget = 3 + 50;                      // reset plus margin
        for (int t = 0; t < N_TESTS; t++) begin
            budget += TEST_CYCLES[t] + 2;
        end
        #(budget * 40);
        $display("timeout, the tests did not finish within %0d cycles", budget);
        $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
rooth_pkg.sv
rooth_bus.sv
rooth_mem.sv
rooth_timer.sv
rooth_soc.sv
rooth_soc_assert.sv
rooth_soc_checker.sv
tb_rooth_soc.sv

// File: run_sim.sh
#!/bin/sh
# build with Verilator, run, and decide on the pass line in the output
verilator --binary --timing --assert -Wno-fatal --top-module tb_rooth_soc -f flist.f \
    && ./obj_dir/Vtb_rooth_soc | tee /dev/stderr | grep -q "Testbench passed" \
    && exit 0 \
    || exit 1
